//--- compile.f
hdl/axi_bridge_pkg.sv
hdl/axi_desc_if.sv
hdl/pending_fifo.sv
hdl/req_decode.sv
hdl/axi_issue.sv
hdl/resp_collect.sv
hdl/mem_axi_bridge.sv
tb/mem_axi_bridge_assert.sv
tb/tb_mem_axi_bridge.sv

//--- hdl/axi_bridge_pkg.sv
// Memory to AXI bridge definitions

package axi_bridge_pkg;

	// ****************************************
	// Plain vector types
	// ****************************************

	// Byte address on both the native and the AXI side
	typedef logic [31:0] addr_t;

	// AXI response code, shared by B and R
	typedef logic [1:0] resp_t;

	// Burst fields of the address channels
	typedef logic [7:0] axi_len_t;
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;

	// ****************************************
	// AXI encodings
	// ****************************************

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// Every transaction is one beat
	localparam axi_len_t   AXI_LEN_SINGLE = 8'd0;
	localparam axi_burst_t AXI_BURST_INCR = 2'b01;

	// ****************************************
	// Issue FSM
	// ****************************************

	typedef enum logic [1:0] {
		ISSUE_IDLE,
		ISSUE_WRITE,
		ISSUE_READ
	} issue_state_t;

endpackage

//--- hdl/axi_desc_if.sv
// Decoded transaction channel

`timescale 1ns/1ps

interface axi_desc_if
	import axi_bridge_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4
);
	logic                    desc_request;
	logic                    desc_write;
	logic [ID_WIDTH-1:0]     desc_id;
	addr_t                   desc_addr;
	logic [DATA_WIDTH-1:0]   desc_wdata;
	logic [DATA_WIDTH/8-1:0] desc_wstrb;
	logic                    desc_ready;

	// Decode side offers, issue side accepts
	modport source (output desc_request, desc_write, desc_id, desc_addr, desc_wdata,
		desc_wstrb, input desc_ready);

	modport sink (input desc_request, desc_write, desc_id, desc_addr, desc_wdata,
		desc_wstrb, output desc_ready);

endinterface

//--- hdl/axi_issue.sv
// AXI address and write data issue stage

`timescale 1ns/1ps

module axi_issue
	import axi_bridge_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	axi_desc_if.sink                desc,
	output logic [ID_WIDTH-1:0]     awid,
	output addr_t                   awaddr,
	output axi_len_t                awlen,
	output axi_size_t               awsize,
	output axi_burst_t              awburst,
	output logic                    awvalid,
	input  logic                    awready,
	output logic [DATA_WIDTH-1:0]   wdata,
	output logic [DATA_WIDTH/8-1:0] wstrb,
	output logic                    wlast,
	output logic                    wvalid,
	input  logic                    wready,
	output logic [ID_WIDTH-1:0]     arid,
	output addr_t                   araddr,
	output axi_len_t                arlen,
	output axi_size_t               arsize,
	output axi_burst_t              arburst,
	output logic                    arvalid,
	input  logic                    arready,
	output logic                    wr_push,
	output logic [ID_WIDTH-1:0]     wr_push_id,
	input  logic                    wr_full,
	output logic                    rd_push,
	output logic [ID_WIDTH-1:0]     rd_push_id,
	input  logic                    rd_full
);
	// Full-width beats only
	localparam axi_size_t BEAT_SIZE = axi_size_t'($clog2(DATA_WIDTH / 8));

	issue_state_t        state;
	logic [ID_WIDTH-1:0] issue_id;
	addr_t               issue_addr;
	logic                aw_done;
	logic                w_done;

	// One descriptor at a time, and only with room in its FIFO
	assign desc.desc_ready = (state == ISSUE_IDLE) && (desc.desc_write ? !wr_full : !rd_full);

	assign wr_push    = desc.desc_request && desc.desc_write;
	assign rd_push    = desc.desc_request && !desc.desc_write;
	assign wr_push_id = desc.desc_id;
	assign rd_push_id = desc.desc_id;

	// A channel is done once its valid is gone or accepted this cycle
	assign aw_done = !awvalid || awready;
	assign w_done  = !wvalid || wready;

	always_ff @(posedge clk) begin
		if (desc.desc_request) begin
			issue_id   <= desc.desc_id;
			issue_addr <= desc.desc_addr;
			wdata      <= desc.desc_wdata;
			wstrb      <= desc.desc_wstrb;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ISSUE_IDLE;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			arvalid <= 1'b0;
		end else begin
			case (state)
				ISSUE_IDLE: begin
					if (desc.desc_request && desc.desc_write) begin
						state   <= ISSUE_WRITE;
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
					end else if (desc.desc_request) begin
						state   <= ISSUE_READ;
						arvalid <= 1'b1;
					end
				end
				ISSUE_WRITE: begin
					// AW and W retire on their own handshakes
					awvalid <= awvalid && !awready;
					wvalid  <= wvalid && !wready;
					if (aw_done && w_done) begin
						state <= ISSUE_IDLE;
					end
				end
				ISSUE_READ: begin
					if (arready) begin
						arvalid <= 1'b0;
						state   <= ISSUE_IDLE;
					end
				end
				default: state <= ISSUE_IDLE;
			endcase
		end
	end

	assign awid    = issue_id;
	assign awaddr  = issue_addr;
	assign awlen   = AXI_LEN_SINGLE;
	assign awsize  = BEAT_SIZE;
	assign awburst = AXI_BURST_INCR;
	assign wlast   = 1'b1;

	assign arid    = issue_id;
	assign araddr  = issue_addr;
	assign arlen   = AXI_LEN_SINGLE;
	assign arsize  = BEAT_SIZE;
	assign arburst = AXI_BURST_INCR;

endmodule

//--- hdl/mem_axi_bridge.sv
// Native memory port to AXI4 bridge

`timescale 1ns/1ps

module mem_axi_bridge
	import axi_bridge_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4,
	parameter int FIFO_DEPTH = 3
) (
	input  logic                    clk,
	input  logic                    rst_n,
	// Native request and response ports
	output logic                    req_ready,
	input  logic                    req_request,
	input  logic                    req_write,
	input  addr_t                   req_addr,
	input  logic [DATA_WIDTH-1:0]   req_wdata,
	input  logic [DATA_WIDTH/8-1:0] req_byte_enable,
	input  logic                    wresp_ready,
	output logic                    wresp_request,
	output logic                    wresp_error,
	input  logic                    rresp_ready,
	output logic                    rresp_request,
	output logic [DATA_WIDTH-1:0]   rresp_data,
	output logic                    rresp_error,
	// AXI master
	output logic [ID_WIDTH-1:0]     awid,
	output addr_t                   awaddr,
	output axi_len_t                awlen,
	output axi_size_t               awsize,
	output axi_burst_t              awburst,
	output logic                    awvalid,
	input  logic                    awready,
	output logic [DATA_WIDTH-1:0]   wdata,
	output logic [DATA_WIDTH/8-1:0] wstrb,
	output logic                    wlast,
	output logic                    wvalid,
	input  logic                    wready,
	input  logic [ID_WIDTH-1:0]     bid,
	input  resp_t                   bresp,
	input  logic                    bvalid,
	output logic                    bready,
	output logic [ID_WIDTH-1:0]     arid,
	output addr_t                   araddr,
	output axi_len_t                arlen,
	output axi_size_t               arsize,
	output axi_burst_t              arburst,
	output logic                    arvalid,
	input  logic                    arready,
	input  logic [ID_WIDTH-1:0]     rid,
	input  logic [DATA_WIDTH-1:0]   rdata,
	input  resp_t                   rresp,
	input  logic                    rlast,
	input  logic                    rvalid,
	output logic                    rready
);
	logic                wr_push;
	logic [ID_WIDTH-1:0] wr_push_id;
	logic                wr_full;
	logic                wr_pop;
	logic [ID_WIDTH-1:0] wr_head_id;
	logic                wr_empty;
	logic                rd_push;
	logic [ID_WIDTH-1:0] rd_push_id;
	logic                rd_full;
	logic                rd_pop;
	logic [ID_WIDTH-1:0] rd_head_id;
	logic                rd_empty;

	axi_desc_if #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) desc_bus ();

	// ****************************************
	// Decode and issue
	// ****************************************

	req_decode #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_req_decode (
		.clk(clk), .rst_n(rst_n),
		.req_ready(req_ready), .req_request(req_request), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata), .req_byte_enable(req_byte_enable),
		.desc(desc_bus.source)
	);

	axi_issue #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_axi_issue (
		.clk(clk), .rst_n(rst_n), .desc(desc_bus.sink),
		.awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize),
		.awburst(awburst), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
		.arburst(arburst), .arvalid(arvalid), .arready(arready),
		.wr_push(wr_push), .wr_push_id(wr_push_id), .wr_full(wr_full),
		.rd_push(rd_push), .rd_push_id(rd_push_id), .rd_full(rd_full)
	);

	// ****************************************
	// Outstanding IDs, one FIFO per direction
	// ****************************************

	pending_fifo #(.ID_WIDTH(ID_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_wr_pending (
		.clk(clk), .rst_n(rst_n), .push(wr_push), .push_id(wr_push_id), .full(wr_full),
		.pop(wr_pop), .head_id(wr_head_id), .empty(wr_empty)
	);

	pending_fifo #(.ID_WIDTH(ID_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_rd_pending (
		.clk(clk), .rst_n(rst_n), .push(rd_push), .push_id(rd_push_id), .full(rd_full),
		.pop(rd_pop), .head_id(rd_head_id), .empty(rd_empty)
	);

	resp_collect #(.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH)) u_resp_collect (
		.clk(clk), .rst_n(rst_n),
		.bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready),
		.rid(rid), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid),
		.rready(rready),
		.wr_head_id(wr_head_id), .wr_empty(wr_empty), .wr_pop(wr_pop),
		.rd_head_id(rd_head_id), .rd_empty(rd_empty), .rd_pop(rd_pop),
		.wresp_ready(wresp_ready), .wresp_request(wresp_request), .wresp_error(wresp_error),
		.rresp_ready(rresp_ready), .rresp_request(rresp_request), .rresp_data(rresp_data),
		.rresp_error(rresp_error)
	);

endmodule

//--- hdl/pending_fifo.sv
// Outstanding ID FIFO

`timescale 1ns/1ps

module pending_fifo #(
	parameter int ID_WIDTH   = 4,
	parameter int FIFO_DEPTH = 3
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                push,
	input  logic [ID_WIDTH-1:0] push_id,
	output logic                full,
	input  logic                pop,
	output logic [ID_WIDTH-1:0] head_id,
	output logic                empty
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [ID_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                do_push;
	logic                do_pop;

	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign empty   = (count == '0);
	assign head_id = mem[rd_ptr];

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_id;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- hdl/req_decode.sv
// Native request decode stage

`timescale 1ns/1ps

module req_decode
	import axi_bridge_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic                    req_ready,
	input  logic                    req_request,
	input  logic                    req_write,
	input  addr_t                   req_addr,
	input  logic [DATA_WIDTH-1:0]   req_wdata,
	input  logic [DATA_WIDTH/8-1:0] req_byte_enable,
	axi_desc_if.source              desc
);
	// Low address bits below one word
	localparam addr_t ALIGN_MASK = addr_t'(DATA_WIDTH / 8 - 1);

	logic                    hold_valid;
	logic                    hold_write;
	logic [ID_WIDTH-1:0]     hold_id;
	addr_t                   hold_addr;
	logic [DATA_WIDTH-1:0]   hold_wdata;
	logic [DATA_WIDTH/8-1:0] hold_wstrb;
	logic [ID_WIDTH-1:0]     wr_id_cnt;
	logic [ID_WIDTH-1:0]     rd_id_cnt;
	logic                    capture;

	assign req_ready = !hold_valid;
	assign capture   = req_request && req_ready;

	// ****************************************
	// Holding register
	// ****************************************

	always_ff @(posedge clk) begin
		if (capture) begin
			hold_write <= req_write;
			hold_id    <= req_write ? wr_id_cnt : rd_id_cnt;
			hold_addr  <= req_addr & ~ALIGN_MASK;
			hold_wdata <= req_wdata;
			hold_wstrb <= req_byte_enable;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hold_valid <= 1'b0;
			wr_id_cnt  <= '0;
			rd_id_cnt  <= '0;
		end else begin
			if (capture) begin
				hold_valid <= 1'b1;
			end else if (desc.desc_request) begin
				hold_valid <= 1'b0;
			end
			// IDs count separately per direction
			if (capture && req_write) begin
				wr_id_cnt <= wr_id_cnt + 1'b1;
			end
			if (capture && !req_write) begin
				rd_id_cnt <= rd_id_cnt + 1'b1;
			end
		end
	end

	// ****************************************
	// Descriptor offer
	// ****************************************

	assign desc.desc_request = hold_valid && desc.desc_ready;
	assign desc.desc_write   = hold_write;
	assign desc.desc_id      = hold_id;
	assign desc.desc_addr    = hold_addr;
	assign desc.desc_wdata   = hold_wdata;
	assign desc.desc_wstrb   = hold_wstrb;

endmodule

//--- hdl/resp_collect.sv
// AXI response collection stage

`timescale 1ns/1ps

module resp_collect
	import axi_bridge_pkg::*;
#(
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH   = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [ID_WIDTH-1:0]   bid,
	input  resp_t                 bresp,
	input  logic                  bvalid,
	output logic                  bready,
	input  logic [ID_WIDTH-1:0]   rid,
	input  logic [DATA_WIDTH-1:0] rdata,
	input  resp_t                 rresp,
	input  logic                  rlast,
	input  logic                  rvalid,
	output logic                  rready,
	input  logic [ID_WIDTH-1:0]   wr_head_id,
	input  logic                  wr_empty,
	output logic                  wr_pop,
	input  logic [ID_WIDTH-1:0]   rd_head_id,
	input  logic                  rd_empty,
	output logic                  rd_pop,
	input  logic                  wresp_ready,
	output logic                  wresp_request,
	output logic                  wresp_error,
	input  logic                  rresp_ready,
	output logic                  rresp_request,
	output logic [DATA_WIDTH-1:0] rresp_data,
	output logic                  rresp_error
);
	logic b_hs;
	logic r_hs;
	logic wr_pend;
	logic rd_pend;

	// Accept a response only when the native side can take it
	assign bready = wresp_ready && !wr_empty;
	assign rready = rresp_ready && !rd_empty;
	assign b_hs   = bvalid && bready;
	assign r_hs   = rvalid && rready;
	assign wr_pop = b_hs;
	assign rd_pop = r_hs;

	// Error payload, captured with each handshake
	always_ff @(posedge clk) begin
		if (b_hs) begin
			wresp_error <= (bresp != RESP_OKAY) || (bid != wr_head_id);
		end
		if (r_hs) begin
			// A single-beat read must also be the last beat
			rresp_error <= (rresp != RESP_OKAY) || (rid != rd_head_id) || !rlast;
			rresp_data  <= rdata;
		end
	end

	// Pending flags hold a response while ready is low
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_pend <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			wr_pend <= b_hs || (wr_pend && !wresp_ready);
			rd_pend <= r_hs || (rd_pend && !rresp_ready);
		end
	end

	assign wresp_request = wr_pend && wresp_ready;
	assign rresp_request = rd_pend && rresp_ready;

endmodule

//--- run.sh
#!/bin/bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_mem_axi_bridge \
	-o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

grep -qx "TEST OK" sim.log && exit 0 || exit 1

//--- tb/mem_axi_bridge_assert.sv
// Bridge port assertions

`timescale 1ns/1ps

module mem_axi_bridge_assert
	import axi_bridge_pkg::*;
(
	input logic     clk,
	input logic     rst_n,
	input logic     awvalid,
	input logic     awready,
	input addr_t    awaddr,
	input axi_len_t awlen,
	input logic     arvalid,
	input logic     arready,
	input addr_t    araddr,
	input axi_len_t arlen,
	input logic     wresp_request,
	input logic     wresp_ready,
	input logic     rresp_request,
	input logic     rresp_ready
);
	// ****************************************
	// AXI address channels
	// ****************************************

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid or awaddr changed before awready");

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid or araddr changed before arready");

	single_beat: assert property (@(posedge clk) disable iff (!rst_n)
		awlen == AXI_LEN_SINGLE && arlen == AXI_LEN_SINGLE)
		else $error("burst length is not a single beat");

	// Native response strobes need ready
	wresp_gate: assert property (@(posedge clk) disable iff (!rst_n)
		wresp_request |-> wresp_ready)
		else $error("wresp_request while wresp_ready low");

	rresp_gate: assert property (@(posedge clk) disable iff (!rst_n)
		rresp_request |-> rresp_ready)
		else $error("rresp_request while rresp_ready low");

endmodule

bind mem_axi_bridge mem_axi_bridge_assert u_bridge_assert (
	.clk(clk), .rst_n(rst_n), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.awlen(awlen), .arvalid(arvalid), .arready(arready), .araddr(araddr), .arlen(arlen),
	.wresp_request(wresp_request), .wresp_ready(wresp_ready),
	.rresp_request(rresp_request), .rresp_ready(rresp_ready)
);

//--- tb/tb_mem_axi_bridge.sv
// Memory to AXI bridge testbench

`timescale 1ns/1ps

module tb_mem_axi_bridge
	import axi_bridge_pkg::*;
();

	localparam int DATA_WIDTH  = 32;
	localparam int ID_WIDTH    = 4;
	localparam int FIFO_DEPTH  = 3;
	localparam int NUM_ENTRIES = 10;
	// 40 cycles of 8 ns per table entry
	localparam int WATCHDOG_NS = NUM_ENTRIES * 40 * 8;

	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  be;
		logic        err;
	} stim_t;

	logic clk, rst_n;
	logic req_ready, req_request, req_write;
	addr_t req_addr;
	logic [31:0] req_wdata;
	logic [3:0] req_byte_enable;
	logic wresp_ready, wresp_request, wresp_error;
	logic rresp_ready, rresp_request, rresp_error;
	logic [31:0] rresp_data;
	logic [ID_WIDTH-1:0] awid, arid, bid, rid;
	addr_t awaddr, araddr;
	axi_len_t awlen, arlen;
	axi_size_t awsize, arsize;
	axi_burst_t awburst, arburst;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rlast, rvalid, rready;
	logic [31:0] wdata, rdata;
	logic [3:0] wstrb;
	resp_t bresp, rresp;

	stim_t stim [NUM_ENTRIES];
	logic [31:0] slave_mem [64];
	logic [31:0] ref_mem [64];
	logic [ID_WIDTH+31:0] aw_q [$];
	logic [35:0] w_q [$];
	logic [ID_WIDTH+1:0] b_q [$];
	logic [ID_WIDTH+31:0] ar_q [$];
	logic [ID_WIDTH+33:0] r_q [$];
	logic wr_exp_q [$];
	logic [32:0] rd_exp_q [$];
	int seed = 41;
	int aw_wait, w_wait, ar_wait;
	int value_errors, other_errors;
	int wr_sent, rd_sent, wr_seen, rd_seen;
	logic stall_resp, b_done, r_done;

	mem_axi_bridge #(
		.DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)
	) dut0 (
		.clk(clk), .rst_n(rst_n), .req_ready(req_ready), .req_request(req_request),
		.req_write(req_write), .req_addr(req_addr), .req_wdata(req_wdata),
		.req_byte_enable(req_byte_enable), .wresp_ready(wresp_ready),
		.wresp_request(wresp_request), .wresp_error(wresp_error), .rresp_ready(rresp_ready),
		.rresp_request(rresp_request), .rresp_data(rresp_data), .rresp_error(rresp_error),
		.awid(awid), .awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
		.awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb), .wlast(wlast),
		.wvalid(wvalid), .wready(wready), .bid(bid), .bresp(bresp), .bvalid(bvalid),
		.bready(bready), .arid(arid), .araddr(araddr), .arlen(arlen), .arsize(arsize),
		.arburst(arburst), .arvalid(arvalid), .arready(arready), .rid(rid), .rdata(rdata),
		.rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Initial contents differ for every word address
	function automatic logic [31:0] fill_word(input int i);
		return {8'h5A, 8'(i), ~8'(i), 8'(i * 7)};
	endfunction

	function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	// ****************************************
	// AXI slave model
	// ****************************************

	always @(negedge clk) begin
		awready = (aw_wait == 0);
		wready  = (w_wait == 0);
		arready = (ar_wait == 0);
		if (b_done) bvalid = 1'b0;
		if (r_done) rvalid = 1'b0;
		b_done = 1'b0;
		r_done = 1'b0;
		if (!bvalid && b_q.size() > 0 && !stall_resp) begin
			{bid, bresp} = b_q[0];
			bvalid = 1'b1;
		end
		if (!rvalid && r_q.size() > 0 && !stall_resp) begin
			{rid, rresp, rdata} = r_q[0];
			rvalid = 1'b1;
		end
		// Native side randomly refuses responses
		wresp_ready = (($unsigned($random(seed)) % 4) != 0);
		rresp_ready = (($unsigned($random(seed)) % 4) != 0);
	end

	always @(posedge clk) begin : slave_sample
		logic [ID_WIDTH-1:0] id;
		logic [31:0] addr;
		logic [35:0] wbeat;
		if (awvalid && awready) begin
			// Single four-byte INCR beat
			check_value("awsize", 32'(awsize), 32'd2);
			check_value("awburst", 32'(awburst), 32'd1);
			aw_q.push_back({awid, awaddr});
			aw_wait = $unsigned($random(seed)) % 4;
		end else if (awvalid && aw_wait > 0) aw_wait--;
		if (wvalid && wready) begin
			check_value("wlast", 32'(wlast), 32'd1);
			w_q.push_back({wstrb, wdata});
			w_wait = $unsigned($random(seed)) % 4;
		end else if (wvalid && w_wait > 0) w_wait--;
		if (arvalid && arready) begin
			check_value("arsize", 32'(arsize), 32'd2);
			check_value("arburst", 32'(arburst), 32'd1);
			ar_q.push_back({arid, araddr});
			ar_wait = $unsigned($random(seed)) % 4;
		end else if (arvalid && ar_wait > 0) ar_wait--;
		if (bvalid && bready) begin
			void'(b_q.pop_front());
			b_done = 1'b1;
		end
		if (rvalid && rready) begin
			void'(r_q.pop_front());
			r_done = 1'b1;
		end
		while (aw_q.size() > 0 && w_q.size() > 0) begin
			{id, addr} = aw_q.pop_front();
			wbeat = w_q.pop_front();
			if (addr >= 32'h100) begin
				b_q.push_back({id, RESP_SLVERR});
			end else begin
				slave_mem[addr[7:2]] = merge_word(slave_mem[addr[7:2]], wbeat[31:0],
					wbeat[35:32]);
				b_q.push_back({id, RESP_OKAY});
			end
		end
		while (ar_q.size() > 0) begin
			{id, addr} = ar_q.pop_front();
			if (addr >= 32'h100) r_q.push_back({id, RESP_SLVERR, 32'h0});
			else r_q.push_back({id, RESP_OKAY, slave_mem[addr[7:2]]});
		end
	end

	// ****************************************
	// Response monitor
	// ****************************************

	always @(posedge clk) begin : collect_responses
		logic [32:0] rexp;
		if (rst_n && wresp_request) begin
			wr_seen++;
			if (wr_exp_q.size() == 0) begin
				$display("write response at %0t with no write outstanding", $time);
				other_errors++;
			end else check_value("wresp_error", 32'(wresp_error), 32'(wr_exp_q.pop_front()));
		end
		if (rst_n && rresp_request) begin
			rd_seen++;
			if (rd_exp_q.size() == 0) begin
				$display("read response at %0t with no read outstanding", $time);
				other_errors++;
			end else begin
				rexp = rd_exp_q.pop_front();
				check_value("rresp_error", 32'(rresp_error), 32'(rexp[32]));
				check_value("rresp_data", rresp_data, rexp[31:0]);
			end
		end
	end

	task automatic send_request(input int idx);
		stim_t s;
		s = stim[idx];
		@(negedge clk);
		while (!req_ready) @(negedge clk);
		req_request     = 1'b1;
		req_write       = s.write;
		req_addr        = s.addr;
		req_wdata       = s.wdata;
		req_byte_enable = s.be;
		if (s.write) begin
			if (!s.err) ref_mem[s.addr[7:2]] = merge_word(ref_mem[s.addr[7:2]], s.wdata, s.be);
			wr_exp_q.push_back(s.err);
			wr_sent++;
		end else begin
			rd_exp_q.push_back({s.err, s.err ? 32'h0 : ref_mem[s.addr[7:2]]});
			rd_sent++;
		end
		@(negedge clk);
		req_request = 1'b0;
	endtask

	task automatic wait_responses();
		while (wr_seen < wr_sent || rd_seen < rd_sent) @(negedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: responses did not arrive in time, run stopped");
		$display("TEST FAILED");
		$finish;
	end

	initial begin : main
		int lat;
		rst_n = 1'b0;
		req_request = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		req_byte_enable = '0;
		wresp_ready = 1'b0;
		rresp_ready = 1'b0;
		awready = 1'b0;
		wready = 1'b0;
		arready = 1'b0;
		bvalid = 1'b0;
		bid = '0;
		bresp = RESP_OKAY;
		rvalid = 1'b0;
		rid = '0;
		rresp = RESP_OKAY;
		rdata = '0;
		rlast = 1'b1;
		stall_resp = 1'b0;
		b_done = 1'b0;
		r_done = 1'b0;
		for (int i = 0; i < 64; i++) begin
			slave_mem[i] = fill_word(i);
			ref_mem[i] = fill_word(i);
		end
		// write, addr, wdata, byte_enable, expect_error
		stim[0] = '{1'b1, 32'h10, 32'hDEADBEEF, 4'hF, 1'b0};
		stim[1] = '{1'b1, 32'h14, 32'h12345678, 4'h3, 1'b0};
		stim[2] = '{1'b0, 32'h10, 32'h0, 4'h0, 1'b0};
		stim[3] = '{1'b0, 32'h14, 32'h0, 4'h0, 1'b0};
		stim[4] = '{1'b1, 32'h11, 32'h0000AA00, 4'h2, 1'b0};
		stim[5] = '{1'b0, 32'h12, 32'h0, 4'h0, 1'b0};
		stim[6] = '{1'b1, 32'h100, 32'hCAFEF00D, 4'hF, 1'b1};
		stim[7] = '{1'b0, 32'h104, 32'h0, 4'h0, 1'b1};
		stim[8] = '{1'b1, 32'h3C, 32'h0BADC0DE, 4'hC, 1'b0};
		stim[9] = '{1'b0, 32'h3C, 32'h0, 4'h0, 1'b0};
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("req_ready", 32'(req_ready), 32'd1);
		check_value("valids", 32'({awvalid, wvalid, arvalid, bready, rready}), 32'd0);
		check_value("strobes", 32'({wresp_request, rresp_request}), 32'd0);

		// Pass one, one entry at a time with latency check
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			send_request(i);
			lat = 1;
			while (!(awvalid || arvalid) && lat < 10) begin
				@(negedge clk);
				lat++;
			end
			check_value("issue_latency", 32'(lat), 32'd2);
			wait_responses();
		end

		// Pass two, responses stalled until the write FIFO is full
		stall_resp = 1'b1;
		send_request(0);
		send_request(1);
		send_request(4);
		send_request(6);
		repeat (10) @(negedge clk);
		check_value("req_ready", 32'(req_ready), 32'd0);
		stall_resp = 1'b0;
		send_request(8);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (!stim[i].write) send_request(i);
		end
		wait_responses();
		repeat (10) @(negedge clk);
		check_value("write_count", 32'(wr_seen), 32'(wr_sent));
		check_value("read_count", 32'(rd_seen), 32'(rd_sent));

		$display("errors: %0d mismatches, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
